// ==== common/editor_config.svh ====
`ifndef EDITOR_CONFIG_SVH
`define EDITOR_CONFIG_SVH

// Text grid, 40 x 15 cells
`define MAX_COL 6'd39
`define MAX_ROW 4'd14

// Glyph cell in pixels
`define GLYPH_W 8
`define GLYPH_H 16

// Font covers '0' to '?'
`define FONT_FIRST 7'h30
`define FONT_COUNT 16

`define DRAW_COLOUR 3'd2 // Green

// Editing keys
`define KEY_HOME  7'h0D
`define KEY_UP    7'h11
`define KEY_LEFT  7'h12
`define KEY_DOWN  7'h13
`define KEY_RIGHT 7'h14
`define KEY_END   7'h17

`endif

// ==== common/editor_pkg.sv ====
package editor_pkg;

    `include "editor_config.svh"

    typedef logic [6:0] ascii_t;

    // Cursor position in cells
    typedef logic [5:0] col_t;
    typedef logic [3:0] row_t;

    // Row-major bitmap, MSB is the top-left pixel
    typedef logic [`GLYPH_W*`GLYPH_H-1:0] glyph_t;

    // Frame coordinates for 320 x 240
    typedef logic [8:0] pix_x_t;
    typedef logic [7:0] pix_y_t;

    typedef logic [2:0] colour_t;

    typedef enum logic [2:0]
    {
        CMD_NONE,
        CMD_ADVANCE,
        CMD_LEFT,
        CMD_RIGHT,
        CMD_UP,
        CMD_DOWN,
        CMD_HOME,
        CMD_END
    } cursor_cmd_t;

endpackage

// ==== common/font.hex ====
// One glyph per line for codes 0x30 to 0x3F, 16 rows of 8 pixels
// First byte is the top row, MSB of each byte is the leftmost pixel
00003C66666E76666666663C00000000
00001838781818181818187E00000000
00003C6606060C183060667E00000000
00003C6606061C060606663C00000000
00000C1C3C6CCCFE0C0C0C1E00000000
00007E6060607C060606663C00000000
00001C3060607C666666663C00000000
00007E66060C18183030303000000000
00003C6666663C666666663C00000000
00003C6666663E0606060C3800000000
00000000181800000018180000000000
00000000181800000018183000000000
000000060C18306030180C0600000000
00000000007E00007E00000000000000
0000006030180C060C18306000000000
00003C6666060C181800181800000000

// ==== glyph/font_rom.sv ====
`include "editor_config.svh"

module font_rom
    import editor_pkg::*;
(
    input  ascii_t code,
    output glyph_t glyph
);

    glyph_t font_mem [`FONT_COUNT];
    ascii_t offset;

    initial
    begin
        $readmemh("common/font.hex", font_mem);
    end

    always_comb
    begin
        offset = code - `FONT_FIRST;
        if (code >= `FONT_FIRST && offset < `FONT_COUNT)
            glyph = font_mem[offset[3:0]];
        else
            glyph = '0; // Blank cell
    end

endmodule

// ==== glyph/glyph_rasterizer.sv ====
`include "editor_config.svh"

module glyph_rasterizer
    import editor_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    draw_start,
    input  glyph_t  glyph,
    input  col_t    cell_col,
    input  row_t    cell_row,
    output logic    draw_done,
    output pix_x_t  pix_x,
    output pix_y_t  pix_y,
    output colour_t pix_colour,
    output logic    plot
);

    localparam int LAST_PIX = `GLYPH_W * `GLYPH_H - 1;

    glyph_t     shift_reg;
    logic [6:0] pix_count;
    logic       active;
    col_t       col_q;
    row_t       row_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            active    <= 1'b0;
            pix_count <= '0;
        end
        else if (draw_start)
        begin
            active    <= 1'b1;
            pix_count <= '0;
        end
        else if (active)
        begin
            pix_count <= pix_count + 7'd1;
            if (pix_count == 7'(LAST_PIX))
                active <= 1'b0;
        end
    end

    // Bitmap and cell origin of the glyph being drawn
    always_ff @(posedge clk)
    begin
        if (draw_start)
        begin
            shift_reg <= glyph;
            col_q     <= cell_col;
            row_q     <= cell_row;
        end
        else if (active)
        begin
            shift_reg <= shift_reg << 1;
        end
    end

    // Cell origin is a multiple of the glyph size, so concatenation adds the offset
    assign pix_x      = {col_q, pix_count[2:0]};
    assign pix_y      = {row_q, pix_count[6:3]};
    assign pix_colour = shift_reg[LAST_PIX] ? `DRAW_COLOUR : 3'd0;
    assign plot       = active;
    assign draw_done  = active && pix_count == 7'(LAST_PIX); // With the last write

endmodule

// ==== logic/cursor_tracker.sv ====
`include "editor_config.svh"

module cursor_tracker
    import editor_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  cursor_cmd_t cursor_cmd,
    output col_t        cursor_col,
    output row_t        cursor_row
);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cursor_col <= '0;
            cursor_row <= '0;
        end
        else
        begin
            case (cursor_cmd)
                CMD_ADVANCE, CMD_RIGHT:
                begin
                    if (cursor_col == `MAX_COL)
                    begin
                        cursor_col <= '0;
                        cursor_row <= (cursor_row == `MAX_ROW) ? 4'd0 : cursor_row + 4'd1;
                    end
                    else
                        cursor_col <= cursor_col + 6'd1;
                end
                CMD_LEFT:
                begin
                    // Wrap to the end of the previous line
                    if (cursor_col == '0)
                    begin
                        cursor_col <= `MAX_COL;
                        cursor_row <= (cursor_row == '0) ? `MAX_ROW : cursor_row - 4'd1;
                    end
                    else
                        cursor_col <= cursor_col - 6'd1;
                end
                CMD_UP:   if (cursor_row != '0) cursor_row <= cursor_row - 4'd1;
                CMD_DOWN: if (cursor_row != `MAX_ROW) cursor_row <= cursor_row + 4'd1;
                CMD_HOME: cursor_col <= '0;
                CMD_END:  cursor_col <= `MAX_COL;
                default:  ;
            endcase
        end
    end

endmodule

// ==== logic/edit_control.sv ====
`include "editor_config.svh"

module edit_control
    import editor_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  ascii_t      char_code,
    input  logic        char_valid,
    input  logic        draw_done,
    output logic        busy,
    output logic        draw_start,
    output ascii_t      draw_code,
    output cursor_cmd_t cursor_cmd
);

    localparam ascii_t PRINT_FIRST = 7'h20;
    localparam ascii_t PRINT_LAST  = 7'h7E;

    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_DRAW,
        ST_ADVANCE,
        ST_MOVE
    } state_t;

    state_t      state;
    cursor_cmd_t move_cmd;
    cursor_cmd_t key_cmd;
    logic        printable;

    // Classify the incoming code
    always_comb
    begin
        printable = char_code >= PRINT_FIRST && char_code <= PRINT_LAST;
        case (char_code)
            `KEY_HOME:  key_cmd = CMD_HOME;
            `KEY_UP:    key_cmd = CMD_UP;
            `KEY_LEFT:  key_cmd = CMD_LEFT;
            `KEY_DOWN:  key_cmd = CMD_DOWN;
            `KEY_RIGHT: key_cmd = CMD_RIGHT;
            `KEY_END:   key_cmd = CMD_END;
            default:    key_cmd = CMD_NONE; // Junk, dropped
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= ST_IDLE;
            draw_start <= 1'b0;
            move_cmd   <= CMD_NONE;
        end
        else
        begin
            draw_start <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (char_valid && printable)
                    begin
                        draw_start <= 1'b1;
                        state      <= ST_DRAW;
                    end
                    else if (char_valid && key_cmd != CMD_NONE)
                    begin
                        move_cmd <= key_cmd;
                        state    <= ST_MOVE;
                    end
                end
                ST_DRAW:    if (draw_done) state <= ST_ADVANCE;
                ST_ADVANCE: state <= ST_IDLE; // Cursor settles here
                ST_MOVE:    state <= ST_IDLE;
                default:    state <= ST_IDLE;
            endcase
        end
    end

    // Code held for the font lookup during the draw
    always_ff @(posedge clk)
    begin
        if (state == ST_IDLE && char_valid && printable)
            draw_code <= char_code;
    end

    always_comb
    begin
        case (state)
            ST_DRAW: cursor_cmd = draw_done ? CMD_ADVANCE : CMD_NONE;
            ST_MOVE: cursor_cmd = move_cmd;
            default: cursor_cmd = CMD_NONE;
        endcase
    end

    assign busy = state != ST_IDLE;

endmodule

// ==== logic/text_editor_top.sv ====
module text_editor_top
(
    input  logic              clk,
    input  logic              reset,
    input  editor_pkg::ascii_t  char_code,
    input  logic              char_valid,
    output logic              busy,
    output editor_pkg::pix_x_t  pix_x,
    output editor_pkg::pix_y_t  pix_y,
    output editor_pkg::colour_t pix_colour,
    output logic              plot,
    output editor_pkg::col_t    cursor_col,
    output editor_pkg::row_t    cursor_row
);

    logic                    draw_start;
    logic                    draw_done;
    editor_pkg::ascii_t      draw_code;
    editor_pkg::glyph_t      glyph;
    editor_pkg::cursor_cmd_t cursor_cmd;

    edit_control edit_control_i (
        .clk        (clk),
        .reset      (reset),
        .char_code  (char_code),
        .char_valid (char_valid),
        .draw_done  (draw_done),
        .busy       (busy),
        .draw_start (draw_start),
        .draw_code  (draw_code),
        .cursor_cmd (cursor_cmd)
    );

    cursor_tracker cursor_tracker_i (
        .clk        (clk),
        .reset      (reset),
        .cursor_cmd (cursor_cmd),
        .cursor_col (cursor_col),
        .cursor_row (cursor_row)
    );

    font_rom font_rom_i (
        .code  (draw_code),
        .glyph (glyph)
    );

    glyph_rasterizer glyph_rasterizer_i (
        .clk        (clk),
        .reset      (reset),
        .draw_start (draw_start),
        .glyph      (glyph),
        .cell_col   (cursor_col),
        .cell_row   (cursor_row),
        .draw_done  (draw_done),
        .pix_x      (pix_x),
        .pix_y      (pix_y),
        .pix_colour (pix_colour),
        .plot       (plot)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module text_editor_tb -f text_editor_top.f -o sim_text_editor
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_text_editor > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi
echo "Simulation finished cleanly"
exit 0

// ==== tb/text_editor_tb.sv ====
`include "editor_config.svh"

module text_editor_tb
    import editor_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PIXELS       = `GLYPH_W * `GLYPH_H;
    localparam int NUM_DIRECTED = 24;
    localparam int NUM_RANDOM   = 200;
    localparam int RESET_CYCLES = 10;
    localparam int TIMEOUT      = (NUM_DIRECTED + NUM_RANDOM) * 140 + RESET_CYCLES + 20;

    logic    clk;
    logic    reset;
    ascii_t  char_code;
    logic    char_valid;
    logic    busy;
    pix_x_t  pix_x;
    pix_y_t  pix_y;
    colour_t pix_colour;
    logic    plot;
    col_t    cursor_col;
    row_t    cursor_row;

    glyph_t      model_font [`FONT_COUNT];
    int          m_col;
    int          m_row;
    logic [31:0] lfsr_state;
    int          cycle_count;

    text_editor_top text_editor_top_i (
        .clk        (clk),
        .reset      (reset),
        .char_code  (char_code),
        .char_valid (char_valid),
        .busy       (busy),
        .pix_x      (pix_x),
        .pix_y      (pix_y),
        .pix_colour (pix_colour),
        .plot       (plot),
        .cursor_col (cursor_col),
        .cursor_row (cursor_row)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_coord(input string name, input pix_x_t exp_x, input pix_y_t exp_y,
                               input pix_x_t act_x, input pix_y_t act_y);
        if (exp_x !== act_x || exp_y !== act_y)
        begin
            $display("[ERROR] %s coord: expected (%0d,%0d), actual (%0d,%0d)",
                     name, exp_x, exp_y, act_x, act_y);
            stop_run();
        end
    endtask

    task automatic check_colour(input string name, input colour_t exp_c, input colour_t act_c);
        if (exp_c !== act_c)
        begin
            $display("[ERROR] %s colour: expected %0d, actual %0d", name, exp_c, act_c);
            stop_run();
        end
    endtask

    task automatic check_cursor(input string name, input col_t exp_col, input row_t exp_row,
                                input col_t act_col, input row_t act_row);
        if (exp_col !== act_col || exp_row !== act_row)
        begin
            $display("[ERROR] %s cursor: expected (%0d,%0d), actual (%0d,%0d)",
                     name, exp_col, exp_row, act_col, act_row);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input string what, input logic exp_v,
                              input logic act_v);
        if (exp_v !== act_v)
        begin
            $display("[ERROR] %s %s: expected %b, actual %b", name, what, exp_v, act_v);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input string what, input int exp_n,
                               input int act_n);
        if (exp_n != act_n)
        begin
            $display("[ERROR] %s %s: expected %0d, actual %0d", name, what, exp_n, act_n);
            stop_run();
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic int take_bits(input int count);
        int   value;
        logic fb;
        value = 0;
        for (int i = 0; i < count; i++)
        begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value = (value << 1) | int'(fb);
        end
        return value;
    endfunction

    function automatic ascii_t key_code(input int idx);
        case (idx)
            0:       return `KEY_HOME;
            1:       return `KEY_UP;
            2:       return `KEY_LEFT;
            3:       return `KEY_DOWN;
            4:       return `KEY_RIGHT;
            default: return `KEY_END;
        endcase
    endfunction

    function automatic logic is_key(input ascii_t code);
        for (int i = 0; i < 6; i++)
            if (code == key_code(i))
                return 1'b1;
        return 1'b0;
    endfunction

    function automatic logic is_printable(input ascii_t code);
        return code >= 7'h20 && code <= 7'h7E;
    endfunction

    function automatic glyph_t model_glyph(input ascii_t code);
        int idx;
        idx = int'(code) - int'(`FONT_FIRST);
        if (idx >= 0 && idx < `FONT_COUNT)
            return model_font[idx];
        return '0; // Blank cell
    endfunction

    // Mix of font chars, other printables, keys and junk controls
    function automatic ascii_t pick_code();
        int kind;
        int v;
        kind = take_bits(2);
        case (kind)
            0:       return 7'(int'(`FONT_FIRST) + take_bits(4));
            1:       return 7'(32 + take_bits(7) % 95);
            2:       return key_code(take_bits(3) % 6);
            default:
            begin
                v = take_bits(5);
                return is_key(7'(v)) ? 7'h7F : 7'(v);
            end
        endcase
    endfunction

    task automatic step_forward();
        if (m_col == int'(`MAX_COL))
        begin
            m_col = 0;
            m_row = (m_row == int'(`MAX_ROW)) ? 0 : m_row + 1;
        end
        else
            m_col = m_col + 1;
    endtask

    task automatic model_apply(input ascii_t code);
        case (code)
            `KEY_RIGHT: step_forward();
            `KEY_LEFT:
            begin
                if (m_col == 0)
                begin
                    m_col = int'(`MAX_COL);
                    m_row = (m_row == 0) ? int'(`MAX_ROW) : m_row - 1;
                end
                else
                    m_col = m_col - 1;
            end
            `KEY_UP:   if (m_row > 0) m_row = m_row - 1;
            `KEY_DOWN: if (m_row < int'(`MAX_ROW)) m_row = m_row + 1;
            `KEY_HOME: m_col = 0;
            `KEY_END:  m_col = int'(`MAX_COL);
            default:   if (is_printable(code)) step_forward();
        endcase
    endtask

    task automatic run_code(input string name, input ascii_t code);
        int     n;
        int     idx;
        int     end_cycle;
        int     move_cycle;
        int     old_col;
        int     old_row;
        logic   drawn;
        logic   exp_plot;
        glyph_t bits;
        @(negedge clk);
        while (busy)
            @(negedge clk);
        check_flag(name, "idle plot", 1'b0, plot);
        @(posedge clk);
        char_code  <= code;
        char_valid <= 1'b1;
        @(posedge clk);
        char_valid <= 1'b0;

        drawn   = is_printable(code);
        bits    = model_glyph(code);
        old_col = m_col;
        old_row = m_row;
        model_apply(code);
        if (drawn)
        begin
            end_cycle  = PIXELS + 3; // Busy falls two cycles after the last write
            move_cycle = PIXELS + 2;
        end
        else if (is_key(code))
        begin
            end_cycle  = 2;
            move_cycle = 2; // Cursor moves as busy falls
        end
        else
        begin
            end_cycle  = 1;
            move_cycle = 1;
        end

        n = 0;
        do
        begin
            @(negedge clk);
            n++;
            exp_plot = drawn && n >= 2 && n <= PIXELS + 1;
            check_flag(name, "plot", exp_plot, plot);
            if (exp_plot)
            begin
                idx = n - 2;
                check_coord(name, pix_x_t'(old_col * `GLYPH_W + idx % `GLYPH_W),
                            pix_y_t'(old_row * `GLYPH_H + idx / `GLYPH_W), pix_x, pix_y);
                check_colour(name, bits[PIXELS - 1 - idx] ? `DRAW_COLOUR : 3'd0, pix_colour);
            end
            if (n >= move_cycle)
                check_cursor(name, col_t'(m_col), row_t'(m_row), cursor_col, cursor_row);
            else
                check_cursor(name, col_t'(old_col), row_t'(old_row), cursor_col, cursor_row);
        end while (busy && n < end_cycle);
        check_flag(name, "busy", 1'b0, busy);
        check_count(name, "busy span", end_cycle, n);
    endtask

    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the DUT never went idle", cycle_count);
        stop_run();
    end

    initial
    begin
        char_code  = '0;
        char_valid = 1'b0;
        reset      = 1'b1;
        lfsr_state = 32'd91032;
        m_col      = 0;
        m_row      = 0;
        $readmemh("common/font.hex", model_font);
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_flag("reset", "busy", 1'b0, busy);
        check_flag("reset", "plot", 1'b0, plot);
        check_cursor("reset", '0, '0, cursor_col, cursor_row);

        // Limits and wraps at the screen corners
        run_code("up at row 0", `KEY_UP);
        run_code("left at origin", `KEY_LEFT);
        run_code("down at row 14", `KEY_DOWN);
        run_code("right at last cell", `KEY_RIGHT);
        run_code("junk control", 7'h01);
        run_code("font char", 7'h30);
        run_code("char outside font", 7'h41);
        run_code("home", `KEY_HOME);
        repeat (14) run_code("down", `KEY_DOWN);
        run_code("end", `KEY_END);
        run_code("print at last cell", 7'h3F);

        for (int k = 0; k < NUM_RANDOM; k++)
            run_code($sformatf("random %0d", k), pick_code());

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== text_editor_top.f ====
+incdir+common
common/editor_pkg.sv
glyph/font_rom.sv
glyph/glyph_rasterizer.sv
logic/cursor_tracker.sv
logic/edit_control.sv
logic/text_editor_top.sv
tb/text_editor_tb.sv
